//--- verilog.f
design/rap_reg_pkg.sv
design/rap_motor_pkg.sv
design/spi_command_port.sv
design/motor_config_regs.sv
design/microstep_sequencer.sv
design/quad_encoder.sv
design/rapcore_top.sv
bench/rapcore_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := rapcore_tb
LINT_TOP   := rapcore_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/rapcore_tb.sv
`timescale 1ns/1ps

module rapcore_tb;

  localparam int HALF_SCK = 8;  // CLK cycles per SCK half period
  // About 22 SPI frames of roughly 700 CLK, plus step bursts and PWM windows, with margin
  localparam int TIMEOUT_CYCLES = 60000;

  logic CLK;
  logic reset;
  logic SCK;
  logic CS;
  logic COPI;
  logic step_in;
  logic dir_in;
  logic enc_a;
  logic enc_b;
  logic CIPO;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic encoder_fault;

  int mismatch_count = 0;
  int error_count    = 0;
  int cycle_count    = 0;

  // Reference state kept by the bench
  int pos_model   = 0;
  int shift_model = 0;
  int cur_model   = 0;
  int enc_model   = 0;
  int enc_idx     = 0;
  bit drv_on         = 1'b0;
  bit fault_expected = 1'b0;

  rapcore_top i_dut (
    .CLK           (CLK),
    .reset         (reset),
    .SCK           (SCK),
    .CS            (CS),
    .COPI          (COPI),
    .step_in       (step_in),
    .dir_in        (dir_in),
    .enc_a         (enc_a),
    .enc_b         (enc_b),
    .CIPO          (CIPO),
    .phase_a1      (phase_a1),
    .phase_a2      (phase_a2),
    .phase_b1      (phase_b1),
    .phase_b2      (phase_b2),
    .encoder_fault (encoder_fault)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("error: run timed out after %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // Driver off means every coil pin low
  assert property (@(posedge CLK) disable iff (reset)
    !drv_on |-> !(phase_a1 || phase_a2 || phase_b1 || phase_b2))
  else begin
    mismatch_count++;
    $display("mismatch at %0t: phase pins expected 0000 got %b%b%b%b", $time,
             $sampled(phase_a1), $sampled(phase_a2), $sampled(phase_b1), $sampled(phase_b2));
  end

  assert property (@(posedge CLK) disable iff (reset)
    !(phase_a1 && phase_a2) && !(phase_b1 && phase_b2))
  else begin
    error_count++;
    $display("error at %0t: both pins of one coil driven at once", $time);
  end

  assert property (@(posedge CLK) disable iff (reset) CS |-> !CIPO)
  else begin
    mismatch_count++;
    $display("mismatch at %0t: CIPO expected 0 got 1", $time);
  end

  assert property (@(posedge CLK) disable iff (reset) !fault_expected |-> !encoder_fault)
  else begin
    error_count++;
    $display("error at %0t: encoder_fault raised without an illegal AB change", $time);
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    end
  endtask

  // Mode 0 frame, stops after bits_sent bits to model an aborted transfer
  task automatic spi_frame(input logic [7:0] op, input logic [31:0] data_out,
                           input int bits_sent, output logic [31:0] data_in);
    logic [39:0] frame;
    frame   = {op, data_out};
    data_in = '0;
    @(posedge CLK);
    CS <= 1'b0;
    repeat (HALF_SCK) @(posedge CLK);
    for (int i = 39; i >= 40 - bits_sent; i--) begin
      COPI <= frame[i];
      repeat (HALF_SCK) @(posedge CLK);
      @(negedge CLK);
      if (i < 32) data_in[i] = CIPO;  // Read word follows the opcode
      @(posedge CLK);
      SCK <= 1'b1;
      repeat (HALF_SCK) @(posedge CLK);
      SCK <= 1'b0;
    end
    repeat (HALF_SCK) @(posedge CLK);
    CS   <= 1'b1;
    COPI <= 1'b0;
    repeat (HALF_SCK) @(posedge CLK);
  endtask

  task automatic write_reg(input logic [7:0] op, input logic [31:0] data);
    logic [31:0] ignored;
    spi_frame(op, data, 40, ignored);
  endtask

  task automatic read_check(input logic [7:0] op, input string name, input int expected);
    logic [31:0] rd;
    spi_frame(op, 32'h0, 40, rd);
    check_value(name, expected, rd);
  endtask

  task automatic step_burst(input int count, input bit up);
    int step_size;
    step_size = 64 >> shift_model;
    @(posedge CLK);
    dir_in <= up;
    repeat (4) @(posedge CLK);
    repeat (count) begin
      step_in <= 1'b1;
      repeat (4) @(posedge CLK);
      step_in <= 1'b0;
      repeat (4) @(posedge CLK);
      pos_model = (pos_model + (up ? step_size : 256 - step_size)) % 256;
    end
    repeat (4) @(posedge CLK);
  endtask

  // Gray order with A leading B, packed {a, b}
  function automatic logic [1:0] gray_state(input int idx);
    case (idx)
      0:       return 2'b00;
      1:       return 2'b10;
      2:       return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic encoder_edges(input int count, input bit up);
    @(posedge CLK);
    repeat (count) begin
      enc_idx = up ? (enc_idx + 1) % 4 : (enc_idx + 3) % 4;
      {enc_a, enc_b} <= gray_state(enc_idx);
      enc_model += up ? 1 : -1;
      repeat (4) @(posedge CLK);
    end
  endtask

  // Counts coil pin high cycles over one full PWM window
  task automatic check_duty();
    int quad;
    int off;
    int mag_a;
    int duty_a;
    int duty_b;
    int cnt[4];
    quad   = pos_model / 64;
    off    = pos_model % 64;
    mag_a  = (quad == 0 || quad == 2) ? 64 - off : off;
    duty_a = (mag_a * cur_model) / 64;
    duty_b = ((64 - mag_a) * cur_model) / 64;
    cnt    = '{0, 0, 0, 0};
    repeat (4) @(posedge CLK);
    repeat (256) begin
      @(negedge CLK);
      cnt[0] += int'(phase_a1);
      cnt[1] += int'(phase_a2);
      cnt[2] += int'(phase_b1);
      cnt[3] += int'(phase_b2);
    end
    check_value("phase_a1 high cycles", (quad == 0 || quad == 3) ? duty_a : 0, cnt[0]);
    check_value("phase_a2 high cycles", (quad == 0 || quad == 3) ? 0 : duty_a, cnt[1]);
    check_value("phase_b1 high cycles", (quad <= 1) ? duty_b : 0, cnt[2]);
    check_value("phase_b2 high cycles", (quad <= 1) ? 0 : duty_b, cnt[3]);
  endtask

  initial begin
    int ms_settings[3];
    logic [31:0] ignored;
    ms_settings = '{0, 3, 9};  // 9 lands on the clamp
    void'($urandom(42));
    reset   = 1'b1;
    SCK     = 1'b0;
    CS      = 1'b1;
    COPI    = 1'b0;
    step_in = 1'b0;
    dir_in  = 1'b0;
    enc_a   = 1'b0;
    enc_b   = 1'b0;
    repeat (16) @(posedge CLK);
    reset <= 1'b0;
    repeat (32) @(posedge CLK);

    // Nonzero current, so only enable keeps the coils quiet
    cur_model = $urandom_range(16, 255);
    write_reg(rap_reg_pkg::OP_WRITE_CURRENT, cur_model);

    // Position tracking while the driver stays off
    foreach (ms_settings[k]) begin
      write_reg(rap_reg_pkg::OP_WRITE_MICROSTEPS, ms_settings[k]);
      shift_model = (ms_settings[k] > 6) ? 6 : ms_settings[k];
      repeat (3) begin
        step_burst($urandom_range(1, 20), 1'($urandom_range(0, 1)));
        read_check(rap_reg_pkg::OP_READ_POSITION, "position", pos_model);
      end
    end

    // Chopper duty and polarity
    write_reg(rap_reg_pkg::OP_WRITE_MICROSTEPS, 3);
    shift_model = 3;
    drv_on = 1'b1;
    write_reg(rap_reg_pkg::OP_WRITE_ENABLE, 1);
    repeat (5) begin
      step_burst($urandom_range(1, 12), 1'($urandom_range(0, 1)));
      check_duty();
    end

    // Encoder counting both ways
    encoder_edges($urandom_range(5, 30), 1'b1);
    read_check(rap_reg_pkg::OP_READ_ENCODER, "encoder_count", enc_model);
    encoder_edges($urandom_range(40, 70), 1'b0);  // Goes negative
    read_check(rap_reg_pkg::OP_READ_ENCODER, "encoder_count", enc_model);
    encoder_edges($urandom_range(1, 30), 1'($urandom_range(0, 1)));
    read_check(rap_reg_pkg::OP_READ_ENCODER, "encoder_count", enc_model);

    // Both pins flip together
    @(posedge CLK);
    fault_expected = 1'b1;
    enc_idx = (enc_idx + 2) % 4;
    {enc_a, enc_b} <= gray_state(enc_idx);
    repeat (6) @(posedge CLK);
    @(negedge CLK);
    check_value("encoder_fault", 1, encoder_fault);
    write_reg(rap_reg_pkg::OP_CLEAR_ENCODER, 0);
    enc_model = 0;
    @(negedge CLK);
    check_value("encoder_fault", 0, encoder_fault);
    fault_expected = 1'b0;
    read_check(rap_reg_pkg::OP_READ_ENCODER, "encoder_count", enc_model);

    // Cut-short writes must not land
    spi_frame(rap_reg_pkg::OP_WRITE_CURRENT, cur_model ^ 8'hff, 20, ignored);
    spi_frame(rap_reg_pkg::OP_WRITE_MICROSTEPS, 0, 39, ignored);  // One bit short
    read_check(rap_reg_pkg::OP_READ_POSITION, "position", pos_model);
    step_burst(2, 1'b1);
    read_check(rap_reg_pkg::OP_READ_POSITION, "position", pos_model);
    check_duty();

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- design/rapcore_top.sv
`timescale 1ns/1ps

module rapcore_top (
  input  logic CLK,
  input  logic reset,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  input  logic step_in,
  input  logic dir_in,
  input  logic enc_a,
  input  logic enc_b,
  output logic CIPO,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic encoder_fault
);

  logic                                          wr_en;
  rap_reg_pkg::spi_opcode_e                      wr_opcode;
  logic [rap_reg_pkg::DATA_BITS-1:0]             wr_data;
  logic [rap_motor_pkg::CURRENT_BITS-1:0]        current;
  logic [rap_motor_pkg::MICROSTEP_BITS-1:0]      microsteps;
  logic                                          enable;
  logic                                          enc_clear;
  logic [rap_motor_pkg::POS_BITS-1:0]            position;
  logic signed [rap_motor_pkg::ENC_BITS-1:0]     encoder_count;

  spi_command_port u_spi (
    .CLK           (CLK),
    .reset         (reset),
    .SCK           (SCK),
    .CS            (CS),
    .COPI          (COPI),
    .encoder_count (encoder_count),
    .position      (position),
    .CIPO          (CIPO),
    .wr_en         (wr_en),
    .wr_opcode     (wr_opcode),
    .wr_data       (wr_data)
  );

  motor_config_regs u_regs (
    .CLK        (CLK),
    .reset      (reset),
    .wr_en      (wr_en),
    .wr_opcode  (wr_opcode),
    .wr_data    (wr_data),
    .current    (current),
    .microsteps (microsteps),
    .enable     (enable),
    .enc_clear  (enc_clear)
  );

  microstep_sequencer u_seq (
    .CLK        (CLK),
    .reset      (reset),
    .step_in    (step_in),
    .dir_in     (dir_in),
    .current    (current),
    .microsteps (microsteps),
    .enable     (enable),
    .position   (position),
    .phase_a1   (phase_a1),
    .phase_a2   (phase_a2),
    .phase_b1   (phase_b1),
    .phase_b2   (phase_b2)
  );

  quad_encoder u_enc (
    .CLK           (CLK),
    .reset         (reset),
    .enc_a         (enc_a),
    .enc_b         (enc_b),
    .enc_clear     (enc_clear),
    .encoder_count (encoder_count),
    .encoder_fault (encoder_fault)
  );

endmodule

//--- design/quad_encoder.sv
`timescale 1ns/1ps

module quad_encoder (
  input  logic                                        CLK,
  input  logic                                        reset,
  input  logic                                        enc_a,
  input  logic                                        enc_b,
  input  logic                                        enc_clear,
  output logic signed [rap_motor_pkg::ENC_BITS-1:0]   encoder_count,
  output logic                                        encoder_fault
);

  // AB pairs packed as {a, b}
  logic [1:0] ab_meta;
  logic [1:0] ab_sync;  // Second stage doubles as the previous state
  logic       a_changed;
  logic       b_changed;
  logic       count_up;

  assign a_changed = ab_meta[1] ^ ab_sync[1];
  assign b_changed = ab_meta[0] ^ ab_sync[0];

  // A leading B gives new A differing from old B
  assign count_up = ab_meta[1] ^ ab_sync[0];

  always_ff @(posedge CLK) begin
    if (reset) begin
      ab_meta       <= '0;
      ab_sync       <= '0;
      encoder_count <= '0;
      encoder_fault <= 1'b0;
    end else begin
      ab_meta <= {enc_a, enc_b};
      ab_sync <= ab_meta;
      if (enc_clear) begin
        encoder_count <= '0;
        encoder_fault <= 1'b0;
      end else if (a_changed && b_changed) begin
        encoder_fault <= 1'b1;  // Sticky until cleared
      end else if (a_changed || b_changed) begin
        if (count_up) begin
          encoder_count <= encoder_count + 1'b1;
        end else begin
          encoder_count <= encoder_count - 1'b1;
        end
      end
    end
  end

endmodule

//--- design/microstep_sequencer.sv
`timescale 1ns/1ps

module microstep_sequencer (
  input  logic                                        CLK,
  input  logic                                        reset,
  input  logic                                        step_in,
  input  logic                                        dir_in,
  input  logic [rap_motor_pkg::CURRENT_BITS-1:0]      current,
  input  logic [rap_motor_pkg::MICROSTEP_BITS-1:0]    microsteps,
  input  logic                                        enable,
  output logic [rap_motor_pkg::POS_BITS-1:0]          position,
  output logic                                        phase_a1,
  output logic                                        phase_a2,
  output logic                                        phase_b1,
  output logic                                        phase_b2
);

  localparam int PROD_BITS = rap_motor_pkg::AMP_BITS + rap_motor_pkg::CURRENT_BITS;

  logic [2:0] step_sync;  // Two sync stages plus edge history
  logic [1:0] dir_sync;
  logic       step_pulse;
  logic       step_up;
  logic [rap_motor_pkg::POS_BITS-1:0]    step_size;
  rap_motor_pkg::quadrant_e              quadrant;
  logic [rap_motor_pkg::OFFSET_BITS-1:0] offset;
  logic [rap_motor_pkg::AMP_BITS-1:0]    mag_a;
  logic [rap_motor_pkg::AMP_BITS-1:0]    mag_b;
  logic [PROD_BITS-1:0]                  prod_a;
  logic [PROD_BITS-1:0]                  prod_b;
  logic [rap_motor_pkg::PWM_BITS-1:0]    duty_a;
  logic [rap_motor_pkg::PWM_BITS-1:0]    duty_b;
  logic [rap_motor_pkg::PWM_BITS-1:0]    pwm_cnt;
  logic                                  a_positive;
  logic                                  b_positive;
  logic                                  a_on;
  logic                                  b_on;

  assign step_size = rap_motor_pkg::FULL_STEP >> microsteps;

  always_ff @(posedge CLK) begin
    if (reset) begin
      step_sync  <= '0;
      dir_sync   <= '0;
      step_pulse <= 1'b0;
      step_up    <= 1'b0;
      position   <= '0;
    end else begin
      step_sync  <= {step_sync[1:0], step_in};
      dir_sync   <= {dir_sync[0], dir_in};
      step_pulse <= step_sync[1] & ~step_sync[2];
      step_up    <= dir_sync[1];
      // Counts regardless of enable, wraps modulo 256
      if (step_pulse) begin
        position <= step_up ? position + step_size : position - step_size;
      end
    end
  end

  assign quadrant = rap_motor_pkg::quadrant_e'(position[rap_motor_pkg::POS_BITS-1 -: 2]);
  assign offset   = position[rap_motor_pkg::OFFSET_BITS-1:0];

  always_comb begin
    case (quadrant)
      rap_motor_pkg::Q0, rap_motor_pkg::Q2: mag_a = rap_motor_pkg::AMP_FULL - {1'b0, offset};
      default:                              mag_a = {1'b0, offset};
    endcase
  end
  assign mag_b = rap_motor_pkg::AMP_FULL - mag_a;  // Coils in quadrature

  assign a_positive = (quadrant == rap_motor_pkg::Q0) || (quadrant == rap_motor_pkg::Q3);
  assign b_positive = (quadrant == rap_motor_pkg::Q0) || (quadrant == rap_motor_pkg::Q1);

  // Scale by current, 64 is full magnitude
  assign prod_a = mag_a * current;
  assign prod_b = mag_b * current;
  assign duty_a = prod_a[rap_motor_pkg::OFFSET_BITS +: rap_motor_pkg::PWM_BITS];
  assign duty_b = prod_b[rap_motor_pkg::OFFSET_BITS +: rap_motor_pkg::PWM_BITS];

  assign a_on = enable && (pwm_cnt < duty_a);
  assign b_on = enable && (pwm_cnt < duty_b);

  always_ff @(posedge CLK) begin
    if (reset) begin
      pwm_cnt  <= '0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else begin
      pwm_cnt  <= pwm_cnt + 1'b1;  // Free running
      phase_a1 <= a_on & a_positive;
      phase_a2 <= a_on & ~a_positive;
      phase_b1 <= b_on & b_positive;
      phase_b2 <= b_on & ~b_positive;
    end
  end

endmodule

//--- design/motor_config_regs.sv
`timescale 1ns/1ps

module motor_config_regs (
  input  logic                                          CLK,
  input  logic                                          reset,
  input  logic                                          wr_en,
  input  rap_reg_pkg::spi_opcode_e                      wr_opcode,
  input  logic [rap_reg_pkg::DATA_BITS-1:0]             wr_data,
  output logic [rap_motor_pkg::CURRENT_BITS-1:0]        current,
  output logic [rap_motor_pkg::MICROSTEP_BITS-1:0]      microsteps,
  output logic                                          enable,
  output logic                                          enc_clear
);

  logic microstep_too_big;

  // Settings beyond the finest resolution saturate
  assign microstep_too_big = wr_data > rap_reg_pkg::DATA_BITS'(rap_motor_pkg::MAX_MICROSTEP_SHIFT);

  always_ff @(posedge CLK) begin
    if (reset) begin
      current    <= '0;
      microsteps <= '0;
      enable     <= 1'b0;
      enc_clear  <= 1'b0;
    end else begin
      enc_clear <= 1'b0;  // Single-cycle pulse
      if (wr_en) begin
        case (wr_opcode)
          rap_reg_pkg::OP_WRITE_CURRENT: begin
            current <= wr_data[rap_motor_pkg::CURRENT_BITS-1:0];
          end
          rap_reg_pkg::OP_WRITE_MICROSTEPS: begin
            if (microstep_too_big) begin
              microsteps <= rap_motor_pkg::MAX_MICROSTEP_SHIFT;
            end else begin
              microsteps <= wr_data[rap_motor_pkg::MICROSTEP_BITS-1:0];
            end
          end
          rap_reg_pkg::OP_WRITE_ENABLE: begin
            enable <= wr_data[0];
          end
          rap_reg_pkg::OP_CLEAR_ENCODER: begin
            enc_clear <= 1'b1;
          end
          default: begin
            // NOP and unknown codes leave the registers alone
          end
        endcase
      end
    end
  end

endmodule

//--- design/spi_command_port.sv
`timescale 1ns/1ps

module spi_command_port (
  input  logic                                       CLK,
  input  logic                                       reset,
  input  logic                                       SCK,
  input  logic                                       CS,
  input  logic                                       COPI,
  input  logic signed [rap_motor_pkg::ENC_BITS-1:0]  encoder_count,
  input  logic        [rap_motor_pkg::POS_BITS-1:0]  position,
  output logic                                       CIPO,
  output logic                                       wr_en,
  output rap_reg_pkg::spi_opcode_e                   wr_opcode,
  output logic        [rap_reg_pkg::DATA_BITS-1:0]   wr_data
);

  typedef enum logic [1:0] {IDLE, OPCODE, DATA} state_e;

  logic [2:0] sck_sync;   // Two sync stages plus edge history
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       copi_bit;
  logic       cs_active;

  state_e                                        state;
  logic [rap_reg_pkg::FRAME_CNT_BITS-1:0]        bit_cnt;
  logic [rap_reg_pkg::OPCODE_BITS-1:0]           op_shift;
  logic [rap_reg_pkg::OPCODE_BITS-1:0]           op_word;
  rap_reg_pkg::spi_opcode_e                      opcode;
  logic [rap_reg_pkg::DATA_BITS-1:0]             rx_shift;
  logic [rap_reg_pkg::DATA_BITS-1:0]             tx_shift;
  logic [rap_reg_pkg::DATA_BITS-1:0]             rd_word;
  logic                                          op_is_read;
  logic                                          opcode_done;
  logic                                          frame_done;
  logic                                          rd_capture;
  logic                                          cipo_q;

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign copi_bit  = copi_sync[1];
  assign cs_active = ~cs_sync[1];

  assign op_word    = {op_shift[rap_reg_pkg::OPCODE_BITS-2:0], copi_bit};
  assign op_is_read = (op_word == rap_reg_pkg::OP_READ_ENCODER) ||
                      (op_word == rap_reg_pkg::OP_READ_POSITION);

  assign opcode_done = (state == OPCODE) && sck_rise &&
                       (bit_cnt == rap_reg_pkg::OPCODE_BITS - 1);
  assign frame_done  = (state == DATA) && sck_rise &&
                       (bit_cnt == rap_reg_pkg::DATA_BITS - 1);

  // Position is zero-extended into the data word
  always_comb begin
    if (opcode == rap_reg_pkg::OP_READ_POSITION) begin
      rd_word = {{(rap_reg_pkg::DATA_BITS - rap_motor_pkg::POS_BITS){1'b0}}, position};
    end else begin
      rd_word = encoder_count;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_sync  <= '0;
      cs_sync   <= '1;  // Deselected
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], SCK};
      cs_sync   <= {cs_sync[0], CS};
      copi_sync <= {copi_sync[0], COPI};
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state      <= IDLE;
      bit_cnt    <= '0;
      rd_capture <= 1'b0;
      wr_en      <= 1'b0;
      cipo_q     <= 1'b0;
    end else begin
      rd_capture <= 1'b0;
      wr_en      <= 1'b0;
      if (!cs_active) begin
        // Partial frame is dropped here
        state   <= IDLE;
        bit_cnt <= '0;
        cipo_q  <= 1'b0;
      end else begin
        case (state)
          IDLE: state <= OPCODE;
          OPCODE: begin
            if (opcode_done) begin
              bit_cnt    <= '0;
              state      <= DATA;
              rd_capture <= op_is_read;
            end else if (sck_rise) begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          DATA: begin
            if (sck_fall) cipo_q <= tx_shift[rap_reg_pkg::DATA_BITS-1];
            if (frame_done) begin
              bit_cnt <= '0;
              state   <= OPCODE;  // Back-to-back frames under one CS
              wr_en   <= (opcode != rap_reg_pkg::OP_NOP) &&
                         (opcode != rap_reg_pkg::OP_READ_ENCODER) &&
                         (opcode != rap_reg_pkg::OP_READ_POSITION);
            end else if (sck_rise) begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Shift registers and the write word
  always_ff @(posedge CLK) begin
    if (state == OPCODE && sck_rise) op_shift <= op_word;
    if (opcode_done) begin
      opcode   <= rap_reg_pkg::spi_opcode_e'(op_word);
      tx_shift <= '0;                  // Writes answer with zeros
    end else if (rd_capture) begin
      tx_shift <= rd_word;
    end else if (state == DATA && sck_fall) begin
      tx_shift <= tx_shift << 1;
    end
    if (state == DATA && sck_rise) begin
      rx_shift <= {rx_shift[rap_reg_pkg::DATA_BITS-2:0], copi_bit};
    end
    if (frame_done) begin
      wr_opcode <= opcode;
      wr_data   <= {rx_shift[rap_reg_pkg::DATA_BITS-2:0], copi_bit};
    end
  end

  assign CIPO = cipo_q & ~CS;

endmodule

//--- design/rap_motor_pkg.sv
package rap_motor_pkg;

  // Electrical position, four full steps per cycle
  localparam int POS_BITS    = 8;
  localparam int OFFSET_BITS = 6;    // Position within one full step

  localparam int MICROSTEP_BITS = 3;
  localparam logic [MICROSTEP_BITS-1:0] MAX_MICROSTEP_SHIFT = 3'd6;

  localparam int PWM_BITS     = 8;   // Chopper period of 256 CLK
  localparam int AMP_BITS     = 7;   // Coil magnitude 0..64
  localparam int CURRENT_BITS = 8;
  localparam int ENC_BITS     = 32;

  // Position increment of one full step at microstep setting 0
  localparam logic [POS_BITS-1:0] FULL_STEP = 8'd64;
  // Peak coil magnitude
  localparam logic [AMP_BITS-1:0] AMP_FULL = 7'd64;

  // Electrical quadrants, top two position bits
  typedef enum logic [1:0] {
    Q0 = 2'd0,
    Q1 = 2'd1,
    Q2 = 2'd2,
    Q3 = 2'd3
  } quadrant_e;

endpackage

//--- design/rap_reg_pkg.sv
package rap_reg_pkg;

  // Frame layout, opcode first and then the data word, both MSB first
  localparam int OPCODE_BITS = 8;
  localparam int DATA_BITS   = 32;

  // Width of the frame bit counter, large enough for the data word
  localparam int FRAME_CNT_BITS = $clog2(DATA_BITS);

  // SPI command set
  typedef enum logic [OPCODE_BITS-1:0] {
    OP_NOP              = 8'h00,
    OP_WRITE_CURRENT    = 8'h10,
    OP_WRITE_MICROSTEPS = 8'h11,
    OP_WRITE_ENABLE     = 8'h12,
    OP_CLEAR_ENCODER    = 8'h13, // Also clears the encoder fault
    OP_READ_ENCODER     = 8'h20,
    OP_READ_POSITION    = 8'h21
  } spi_opcode_e;

endpackage
